// File: source/legv8Pkg.sv
`default_nettype none

package legv8Pkg;

	localparam int XLEN = 32; // Data and address width
	localparam int REG_ADDR_W = 5;
	localparam int REG_COUNT = 32;
	localparam logic [REG_ADDR_W-1:0] ZERO_REG = 5'd31; // X31 is hardwired to zero
	localparam int DMEM_WORDS = 16;
	localparam int DMEM_INDEX_W = 4; // Word index into data memory
	localparam logic [XLEN-1:0] PC_STEP = 32'd4; // Bytes per instruction

	// R-type and D-type opcodes, bits 31 to 21
	localparam logic [10:0] OP_ADD = 11'b100_0101_1000;
	localparam logic [10:0] OP_SUB = 11'b110_0101_1000;
	localparam logic [10:0] OP_AND = 11'b100_0101_0000;
	localparam logic [10:0] OP_ORR = 11'b101_0101_0000;
	localparam logic [10:0] OP_EOR = 11'b110_0101_0000;
	localparam logic [10:0] OP_LDUR = 11'b111_1100_0010;
	localparam logic [10:0] OP_STUR = 11'b111_1100_0000;

	// I-type opcodes, bits 31 to 22
	localparam logic [9:0] OP_ADDI = 10'b10_0100_0100;
	localparam logic [9:0] OP_SUBI = 10'b11_0100_0100;
	localparam logic [9:0] OP_ANDI = 10'b10_0100_1000;
	localparam logic [9:0] OP_ORRI = 10'b10_1100_1000;
	localparam logic [9:0] OP_EORI = 10'b11_0100_1000;

	// CB-type, bits 31 to 24
	localparam logic [7:0] OP_CBZ = 8'b1011_0100;
	localparam logic [7:0] OP_CBNZ = 8'b1011_0101;

	localparam logic [5:0] OP_B = 6'b00_0101; // Bits 31 to 26

	typedef enum logic [2:0] {
		ALU_ADD, // Also address generation for LDUR and STUR
		ALU_SUB,
		ALU_AND,
		ALU_ORR,
		ALU_EOR,
		ALU_PASSB // Second operand straight through
	} aluOpT;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg; // Write back the loaded word
		logic aluSrc; // Immediate as second operand
		logic condZero; // CBZ
		logic condNonZero; // CBNZ
		logic uncond; // B
		aluOpT aluOp;
	} ctrlT;

	typedef struct packed {
		ctrlT ctrl;
		logic [XLEN-1:0] pc;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0] immediate; // Already sign-extended
		logic valid; // Opcode recognized
	} decodedT;

	// Execute result handed to memory and write-back
	typedef struct packed {
		decodedT dec;
		logic [XLEN-1:0] aluResult;
		logic [XLEN-1:0] storeData;
	} execT;

	// One record per retired instruction
	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] pc;
		logic regWrite;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0] regData;
		logic memWrite;
		logic [DMEM_INDEX_W-1:0] memIndex;
		logic [XLEN-1:0] storeData;
	} commitT;

endpackage

`default_nettype wire

// File: source/instructionDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder import legv8Pkg::*; (
	input logic [XLEN-1:0] instr,
	input logic [XLEN-1:0] pc,
	output decodedT dec,
	output logic [REG_ADDR_W-1:0] readAddr1, // Rn
	output logic [REG_ADDR_W-1:0] readAddr2 // Rm or Rt
);

	logic [10:0] op11;
	logic [9:0] op10;
	logic [7:0] op8;
	logic [5:0] op6;
	logic [REG_ADDR_W-1:0] rd;
	logic reg2Loc; // Port 2 reads Rt instead of Rm
	logic matched;
	ctrlT ctrl;
	logic [XLEN-1:0] immediate;

	// Opcode fields of each width
	assign op11 = instr[31:21];
	assign op10 = instr[31:22];
	assign op8 = instr[31:24];
	assign op6 = instr[31:26];
	assign rd = instr[4:0]; // Rd, also Rt for STUR and CB

	// Longest opcode field checked first
	always_comb begin
		ctrl = '0;
		immediate = '0;
		reg2Loc = 1'b0;
		matched = 1'b1;
		if (op11 inside {OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_EOR}) begin // R-type
			ctrl.regWrite = 1'b1;
			case (op11)
				OP_SUB: ctrl.aluOp = ALU_SUB;
				OP_AND: ctrl.aluOp = ALU_AND;
				OP_ORR: ctrl.aluOp = ALU_ORR;
				OP_EOR: ctrl.aluOp = ALU_EOR;
				default: ctrl.aluOp = ALU_ADD;
			endcase
		end else if (op11 == OP_LDUR) begin
			ctrl.regWrite = 1'b1;
			ctrl.memRead = 1'b1;
			ctrl.memToReg = 1'b1;
			ctrl.aluSrc = 1'b1;
			ctrl.aluOp = ALU_ADD; // Base plus offset
			immediate = {{(XLEN-9){instr[20]}}, instr[20:12]};
		end else if (op11 == OP_STUR) begin
			ctrl.memWrite = 1'b1;
			ctrl.aluSrc = 1'b1;
			ctrl.aluOp = ALU_ADD;
			reg2Loc = 1'b1; // Store data comes from Rt
			immediate = {{(XLEN-9){instr[20]}}, instr[20:12]};
		end else if (op10 inside {OP_ADDI, OP_SUBI, OP_ANDI, OP_ORRI, OP_EORI}) begin
			ctrl.regWrite = 1'b1;
			ctrl.aluSrc = 1'b1;
			case (op10)
				OP_SUBI: ctrl.aluOp = ALU_SUB;
				OP_ANDI: ctrl.aluOp = ALU_AND;
				OP_ORRI: ctrl.aluOp = ALU_ORR;
				OP_EORI: ctrl.aluOp = ALU_EOR;
				default: ctrl.aluOp = ALU_ADD;
			endcase
			immediate = {{(XLEN-12){instr[21]}}, instr[21:10]}; // 12-bit immediate
		end else if (op8 == OP_CBZ || op8 == OP_CBNZ) begin
			// Rt tested on port 2
			ctrl.condZero = (op8 == OP_CBZ);
			ctrl.condNonZero = (op8 == OP_CBNZ);
			ctrl.aluOp = ALU_PASSB;
			reg2Loc = 1'b1;
			immediate = {{(XLEN-19){instr[23]}}, instr[23:5]}; // Word offset
		end else if (op6 == OP_B) begin
			ctrl.uncond = 1'b1;
			immediate = {{(XLEN-26){instr[25]}}, instr[25:0]};
		end else begin
			matched = 1'b0; // Unknown word, no writes
		end
	end

	always_comb begin
		dec.ctrl = ctrl;
		dec.ctrl.regWrite = ctrl.regWrite && (rd != ZERO_REG); // Writes to X31 dropped
		dec.pc = pc;
		dec.rd = rd;
		dec.immediate = immediate;
		dec.valid = matched;
	end

	assign readAddr1 = instr[9:5];
	assign readAddr2 = reg2Loc ? instr[4:0] : instr[20:16];

endmodule

`default_nettype wire

// File: source/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile import legv8Pkg::*; (
	input logic clock,
	input logic rst,
	input logic [REG_ADDR_W-1:0] readAddr1,
	input logic [REG_ADDR_W-1:0] readAddr2,
	output logic [XLEN-1:0] readData1,
	output logic [XLEN-1:0] readData2,
	input commitT commit // Write port
);

	logic [XLEN-1:0] regs [REG_COUNT];

	// Write-back from the commit record
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (commit.regWrite) begin
			regs[commit.rd] <= commit.regData;
		end
	end

	// Combinational reads
	always_comb begin
		readData1 = regs[readAddr1];
		readData2 = regs[readAddr2];
		if (readAddr1 == ZERO_REG) begin
			readData1 = '0; // X31 always zero
		end
		if (readAddr2 == ZERO_REG) begin
			readData2 = '0;
		end
	end

endmodule

`default_nettype wire

// File: source/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module executeUnit import legv8Pkg::*; (
	input decodedT dec,
	input logic [XLEN-1:0] readData1,
	input logic [XLEN-1:0] readData2,
	output execT exec,
	output logic branchTaken,
	output logic [XLEN-1:0] branchOffset // Byte offset from the current pc
);

	logic [XLEN-1:0] operandB;
	logic [XLEN-1:0] aluResult;
	logic regIsZero; // CB test on Rt

	assign operandB = dec.ctrl.aluSrc ? dec.immediate : readData2;

	always_comb begin
		case (dec.ctrl.aluOp)
			ALU_SUB: aluResult = readData1 - operandB;
			ALU_AND: aluResult = readData1 & operandB;
			ALU_ORR: aluResult = readData1 | operandB;
			ALU_EOR: aluResult = readData1 ^ operandB;
			ALU_PASSB: aluResult = operandB;
			default: aluResult = readData1 + operandB; // ADD and addresses
		endcase
	end

	assign regIsZero = (readData2 == '0);

	// Branch decision
	always_comb begin
		branchTaken = dec.ctrl.uncond
			|| (dec.ctrl.condZero && regIsZero)
			|| (dec.ctrl.condNonZero && !regIsZero);
		branchTaken = branchTaken && dec.valid;
	end

	assign branchOffset = {dec.immediate[XLEN-3:0], 2'b00}; // Words to bytes

	always_comb begin
		exec.dec = dec;
		exec.aluResult = aluResult;
		exec.storeData = readData2; // Rt for STUR
	end

endmodule

`default_nettype wire

// File: source/memoryWriteback.sv
`timescale 1ns/1ps
`default_nettype none

module memoryWriteback import legv8Pkg::*; (
	input logic clock,
	input logic rst,
	input execT exec,
	output commitT commit
);

	logic [XLEN-1:0] dmem [DMEM_WORDS];
	logic [DMEM_INDEX_W-1:0] memIndex;
	logic [XLEN-1:0] loadWord;

	assign memIndex = exec.aluResult[DMEM_INDEX_W+1:2]; // Wraps past 16 words
	assign loadWord = exec.dec.ctrl.memRead ? dmem[memIndex] : '0;

	// Store lands at the edge that ends the cycle
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (commit.memWrite) begin
			dmem[memIndex] <= exec.storeData;
		end
	end

	always_comb begin
		commit.valid = !rst;
		commit.pc = exec.dec.pc;
		commit.regWrite = exec.dec.ctrl.regWrite && !rst;
		commit.rd = exec.dec.rd;
		commit.regData = exec.dec.ctrl.memToReg ? loadWord : exec.aluResult;
		commit.memWrite = exec.dec.ctrl.memWrite && !rst;
		commit.memIndex = memIndex;
		commit.storeData = exec.storeData;
	end

endmodule

`default_nettype wire

// File: source/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pcUnit import legv8Pkg::*; (
	input logic clock,
	input logic rst,
	input logic branchTaken,
	input logic [XLEN-1:0] branchOffset,
	output logic [XLEN-1:0] pc
);

	logic [XLEN-1:0] seqPc; // Fall-through address
	logic [XLEN-1:0] targetPc;
	logic [XLEN-1:0] nextPc;

	assign seqPc = pc + PC_STEP;
	assign targetPc = pc + branchOffset; // Relative to the branch itself
	assign nextPc = branchTaken ? targetPc : seqPc;

	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

// File: source/legv8Core.sv
`timescale 1ns/1ps
`default_nettype none

module legv8Core import legv8Pkg::*; (
	input logic clock,
	input logic rst,
	input logic [XLEN-1:0] imemData, // Word at imemAddr
	output logic [XLEN-1:0] imemAddr,
	output commitT commit
);

	logic [XLEN-1:0] pc;
	decodedT dec;
	logic [REG_ADDR_W-1:0] readAddr1;
	logic [REG_ADDR_W-1:0] readAddr2;
	logic [XLEN-1:0] readData1;
	logic [XLEN-1:0] readData2;
	execT exec;
	logic branchTaken;
	logic [XLEN-1:0] branchOffset;

	assign imemAddr = pc; // Fetch straight from the PC

	pcUnit u_pcUnit (
		.clock(clock),
		.rst(rst),
		.branchTaken(branchTaken),
		.branchOffset(branchOffset),
		.pc(pc)
	);

	instructionDecoder u_instructionDecoder (
		.instr(imemData),
		.pc(pc),
		.dec(dec),
		.readAddr1(readAddr1),
		.readAddr2(readAddr2)
	);

	// Written back from commit at the next edge
	registerFile u_registerFile (
		.clock(clock),
		.rst(rst),
		.readAddr1(readAddr1),
		.readAddr2(readAddr2),
		.readData1(readData1),
		.readData2(readData2),
		.commit(commit)
	);

	executeUnit u_executeUnit (
		.dec(dec),
		.readData1(readData1),
		.readData2(readData2),
		.exec(exec),
		.branchTaken(branchTaken),
		.branchOffset(branchOffset)
	);

	memoryWriteback u_memoryWriteback (
		.clock(clock),
		.rst(rst),
		.exec(exec),
		.commit(commit)
	);

endmodule

`default_nettype wire

// File: verification/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clock
);

	localparam int HALF_PERIOD = 50; // 100 ns period

	initial begin
		clock = 1'b0;
	end

	always begin
		#(HALF_PERIOD) clock = ~clock;
	end

endmodule

`default_nettype wire

// File: verification/legv8Core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module legv8Core_properties import legv8Pkg::*; (
	input logic clock,
	input logic rst,
	input logic [XLEN-1:0] imemAddr,
	input commitT commit
);

	// No retirement while reset holds the core
	validLowInReset: assert property (@(posedge clock) rst |-> !commit.valid)
		else $error("commit.valid high while rst is high");

	// Loads and ALU ops write a register, stores write memory, never both
	noDualWrite: assert property (@(posedge clock) disable iff (rst)
		!(commit.regWrite && commit.memWrite))
		else $error("regWrite and memWrite set in the same commit");

	noZeroRegWrite: assert property (@(posedge clock) disable iff (rst)
		commit.regWrite |-> (commit.rd != ZERO_REG))
		else $error("register write aimed at X31");

	// Word aligned fetch
	alignedFetch: assert property (@(posedge clock) disable iff (rst)
		imemAddr[1:0] == 2'b00)
		else $error("imemAddr not word aligned");

endmodule

`default_nettype wire

// File: verification/legv8CoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module legv8CoreTb import legv8Pkg::*; ();

	localparam int CLOCK_PERIOD = 100;
	localparam int DRIVE_DELAY = 1; // Inputs change just after the edge
	localparam int SAMPLE_DELAY = CLOCK_PERIOD - 1; // Outputs read just before the edge
	localparam int RESET_CYCLES = 5;
	localparam int PROG_WORDS = 128;
	localparam int CYCLE_LIMIT = 600; // About 80 instructions plus reset and margin
	localparam int RANDOM_SEED = 85;

	logic clock;
	logic rst;
	logic [XLEN-1:0] imemData;
	logic [XLEN-1:0] imemAddr;
	commitT commit;

	logic [XLEN-1:0] progMem [PROG_WORDS];
	string testNames [PROG_WORDS];
	int progLen = 0;
	logic [XLEN-1:0] haltPc; // Final B #0

	// Architectural state of the reference model
	logic [XLEN-1:0] refRegs [REG_COUNT];
	logic [XLEN-1:0] refMem [DMEM_WORDS];
	logic [XLEN-1:0] refPc;

	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	logic runDone = 1'b0;

	clockGen u_clockGen (.clock(clock));

	legv8Core u_dut (
		.clock(clock),
		.rst(rst),
		.imemData(imemData),
		.imemAddr(imemAddr),
		.commit(commit)
	);

	bind legv8Core legv8Core_properties u_properties (
		.clock(clock),
		.rst(rst),
		.imemAddr(imemAddr),
		.commit(commit)
	);

	function automatic logic [31:0] encodeR(input logic [10:0] op, input logic [4:0] rm,
		input logic [4:0] rn, input logic [4:0] rd);
		return {op, rm, 6'd0, rn, rd};
	endfunction

	function automatic logic [31:0] encodeI(input logic [9:0] op, input logic [11:0] imm,
		input logic [4:0] rn, input logic [4:0] rd);
		return {op, imm, rn, rd};
	endfunction

	function automatic logic [31:0] encodeD(input logic [10:0] op, input logic [8:0] offset,
		input logic [4:0] rn, input logic [4:0] rt);
		return {op, offset, 2'b00, rn, rt};
	endfunction

	function automatic logic [31:0] encodeCB(input logic [7:0] op, input logic [18:0] offset,
		input logic [4:0] rt);
		return {op, offset, rt};
	endfunction

	function automatic logic [31:0] encodeB(input logic [25:0] offset);
		return {OP_B, offset};
	endfunction

	task automatic addWord(input logic [31:0] word, input string name);
		progMem[progLen] = word;
		testNames[progLen] = name;
		progLen++;
	endtask

	function automatic logic [31:0] fetchWord(input logic [XLEN-1:0] addr);
		if ((addr >> 2) < PROG_WORDS) begin
			return progMem[addr >> 2];
		end
		return '0; // Outside the program the word decodes as unknown
	endfunction

	function automatic string testNameAt(input logic [XLEN-1:0] addr);
		if ((addr >> 2) < PROG_WORDS) begin
			return testNames[addr >> 2];
		end
		return "fetchRange";
	endfunction

	task automatic buildProgram();
		logic [10:0] rOps [5];
		logic [9:0] iOps [5];
		logic [11:0] imm;
		rOps = '{OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_EOR};
		iOps = '{OP_ADDI, OP_SUBI, OP_ANDI, OP_ORRI, OP_EORI};
		for (int i = 0; i < PROG_WORDS; i++) begin
			progMem[i] = '0;
			testNames[i] = "";
		end
		addWord(encodeR(OP_ADD, 5'd3, 5'd2, 5'd1), "resetState"); // X2 and X3 untouched
		for (int i = 0; i < 8; i++) begin
			imm = 12'($urandom);
			if (i % 2 == 0) begin
				addWord(encodeI(OP_ADDI, imm, 5'd31, 5'($urandom % 31)), "loadAddi");
			end else begin
				addWord(encodeI(OP_ORRI, imm, 5'($urandom), 5'($urandom % 31)), "loadOrri");
			end
		end
		for (int round = 0; round < 4; round++) begin
			for (int k = 0; k < 5; k++) begin
				addWord(encodeR(rOps[k], 5'($urandom), 5'($urandom), 5'($urandom % 31)), "rType");
				imm = 12'($urandom);
				if (round == 0) begin
					imm[11] = 1'b1; // Negative immediates first round
				end
				addWord(encodeI(iOps[k], imm, 5'($urandom), 5'($urandom % 31)), "iType");
			end
		end
		addWord(encodeI(OP_ADDI, 12'd40, 5'd31, 5'd5), "memory"); // Base address
		addWord(encodeI(OP_ORRI, 12'h5A3, 5'd31, 5'd6), "memory");
		addWord(encodeD(OP_STUR, 9'd8, 5'd5, 5'd6), "storeWord"); // Index 12
		addWord(encodeD(OP_LDUR, 9'd8, 5'd5, 5'd7), "loadWord");
		addWord(encodeI(OP_EORI, 12'hFFF, 5'd6, 5'd16), "memory"); // Negative value
		addWord(encodeD(OP_STUR, 9'h1F8, 5'd5, 5'd16), "storeNegOffset"); // Index 8
		addWord(encodeI(OP_ADDI, 12'd112, 5'd31, 5'd8), "memory");
		addWord(encodeD(OP_LDUR, 9'd0, 5'd8, 5'd9), "loadWrap"); // 112 wraps to 12
		addWord(encodeD(OP_LDUR, 9'd32, 5'd31, 5'd10), "loadWord");
		addWord(encodeD(OP_LDUR, 9'd96, 5'd31, 5'd17), "loadWrap"); // 96 wraps to 8
		addWord(encodeCB(OP_CBZ, 19'd2, 5'd31), "cbzTaken");
		addWord(encodeI(OP_ADDI, 12'd1, 5'd31, 5'd11), "cbzTaken"); // Skipped
		addWord(encodeCB(OP_CBZ, 19'd2, 5'd6), "cbzNotTaken");
		addWord(encodeI(OP_ADDI, 12'd2, 5'd31, 5'd11), "cbzNotTaken");
		addWord(encodeCB(OP_CBNZ, 19'd2, 5'd6), "cbnzTaken");
		addWord(encodeI(OP_ADDI, 12'd3, 5'd31, 5'd11), "cbnzTaken"); // Skipped
		addWord(encodeCB(OP_CBNZ, 19'd2, 5'd31), "cbnzNotTaken");
		addWord(encodeI(OP_ADDI, 12'd4, 5'd31, 5'd11), "cbnzNotTaken");
		addWord(encodeB(26'd2), "branchForward");
		addWord(encodeB(26'd2), "branchExit"); // Reached from the backward B
		addWord(encodeB(26'h3FFFFFF), "branchBackward"); // Offset -1
		addWord(encodeI(OP_ADDI, 12'd5, 5'd6, 5'd31), "zeroRegWrite");
		addWord(encodeD(OP_LDUR, 9'd8, 5'd5, 5'd31), "zeroRegWrite");
		addWord(encodeR(OP_ADD, 5'd31, 5'd31, 5'd13), "zeroRegRead");
		addWord(encodeR(OP_ORR, 5'd6, 5'd31, 5'd14), "zeroRegRead");
		addWord(32'hFFFF_FFFF, "unknownWord");
		addWord(32'h0000_0000, "unknownWord");
		addWord(encodeI(OP_ADDI, 12'd7, 5'd31, 5'd15), "afterUnknown");
		haltPc = 32'(progLen * 4);
		addWord(encodeB(26'd0), "halt"); // Spins in place
	endtask

	task automatic resetReference();
		for (int i = 0; i < REG_COUNT; i++) begin
			refRegs[i] = '0;
		end
		for (int i = 0; i < DMEM_WORDS; i++) begin
			refMem[i] = '0;
		end
		refPc = '0;
	endtask

	function automatic logic [XLEN-1:0] regValue(input logic [4:0] index);
		return (index == 5'd31) ? '0 : refRegs[index];
	endfunction

	// Executes one instruction on the reference state and returns the expected commit
	function automatic commitT stepReference(input logic [31:0] instr);
		commitT result;
		logic [XLEN-1:0] rnVal;
		logic [XLEN-1:0] rmVal;
		logic [XLEN-1:0] rtVal;
		logic [XLEN-1:0] immI;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] value;
		logic [XLEN-1:0] nextPc;
		logic writes;
		logic cbTaken;
		result = '0;
		result.valid = 1'b1;
		result.pc = refPc;
		rnVal = regValue(instr[9:5]);
		rmVal = regValue(instr[20:16]);
		rtVal = regValue(instr[4:0]);
		immI = {{20{instr[21]}}, instr[21:10]};
		addr = rnVal + {{23{instr[20]}}, instr[20:12]};
		nextPc = refPc + 32'd4;
		value = '0;
		writes = 1'b1;
		case (instr[31:21])
			OP_ADD: value = rnVal + rmVal;
			OP_SUB: value = rnVal - rmVal;
			OP_AND: value = rnVal & rmVal;
			OP_ORR: value = rnVal | rmVal;
			OP_EOR: value = rnVal ^ rmVal;
			OP_LDUR: value = refMem[addr[5:2]]; // Index wraps at 16 words
			default: writes = 1'b0;
		endcase
		if (!writes) begin
			writes = 1'b1;
			case (instr[31:22])
				OP_ADDI: value = rnVal + immI;
				OP_SUBI: value = rnVal - immI;
				OP_ANDI: value = rnVal & immI;
				OP_ORRI: value = rnVal | immI;
				OP_EORI: value = rnVal ^ immI;
				default: writes = 1'b0;
			endcase
		end
		if (writes && instr[4:0] != 5'd31) begin
			result.regWrite = 1'b1;
			result.rd = instr[4:0];
			result.regData = value;
			refRegs[instr[4:0]] = value;
		end
		if (instr[31:21] == OP_STUR) begin
			result.memWrite = 1'b1;
			result.memIndex = addr[5:2];
			result.storeData = rtVal;
			refMem[addr[5:2]] = rtVal;
		end
		cbTaken = (instr[31:24] == OP_CBZ && rtVal == '0)
			|| (instr[31:24] == OP_CBNZ && rtVal != '0);
		if (cbTaken) begin
			nextPc = refPc + {{11{instr[23]}}, instr[23:5], 2'b00};
		end
		if (instr[31:26] == OP_B) begin
			nextPc = refPc + {{4{instr[25]}}, instr[25:0], 2'b00};
		end
		refPc = nextPc;
		return result;
	endfunction

	task automatic reportValue(input string testName, input string field,
		input logic [XLEN-1:0] expectedValue, input logic [XLEN-1:0] actualValue);
		errorCount++;
		$display("ERROR %s %s: expected %h, actual %h", testName, field, expectedValue, actualValue);
	endtask

	task automatic compareCommit();
		commitT expected;
		string name;
		name = testNameAt(refPc);
		expected = stepReference(fetchWord(refPc));
		checkCount++;
		if (commit.valid !== 1'b1) begin
			errorCount++;
			$display("Commit record not valid in a cycle after reset, test %s", name);
		end
		if (imemAddr !== expected.pc) begin
			reportValue(name, "imemAddr", expected.pc, imemAddr);
		end
		if (commit.pc !== expected.pc) begin
			reportValue(name, "pc", expected.pc, commit.pc);
		end
		if (commit.regWrite !== expected.regWrite) begin
			reportValue(name, "regWrite", expected.regWrite, commit.regWrite);
		end
		if (expected.regWrite && commit.rd !== expected.rd) begin
			reportValue(name, "rd", expected.rd, commit.rd);
		end
		if (expected.regWrite && commit.regData !== expected.regData) begin
			reportValue(name, "regData", expected.regData, commit.regData);
		end
		if (commit.memWrite !== expected.memWrite) begin
			reportValue(name, "memWrite", expected.memWrite, commit.memWrite);
		end
		if (expected.memWrite && commit.memIndex !== expected.memIndex) begin
			reportValue(name, "memIndex", expected.memIndex, commit.memIndex);
		end
		if (expected.memWrite && commit.storeData !== expected.storeData) begin
			reportValue(name, "storeData", expected.storeData, commit.storeData);
		end
		if (expected.pc == haltPc) begin
			runDone = 1'b1; // Halt loop reached
		end
	endtask

	// Instruction fetch model
	always @(posedge clock) begin
		#(DRIVE_DELAY);
		imemData = fetchWord(imemAddr);
	end

	// Commit compare once per cycle
	always begin
		@(posedge clock);
		#(SAMPLE_DELAY);
		if (!runDone && rst && (commit.valid || commit.regWrite || commit.memWrite)) begin
			errorCount++;
			$display("Commit record valid or writing while reset is high");
		end else if (!runDone && !rst) begin
			compareCommit();
		end
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= CYCLE_LIMIT && !runDone) begin
			errorCount++;
			$display("Timeout: the core never reached the halt branch in %0d cycles", CYCLE_LIMIT);
			runDone = 1'b1;
		end
	end

	initial begin
		rst = 1'b1;
		imemData = '0;
		void'($urandom(RANDOM_SEED));
		buildProgram();
		resetReference();
		repeat (RESET_CYCLES) @(posedge clock);
		#(DRIVE_DELAY);
		rst = 1'b0;
		wait (runDone);
		$display("Commits checked: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
source/legv8Pkg.sv
source/instructionDecoder.sv
source/registerFile.sv
source/executeUnit.sv
source/memoryWriteback.sv
source/pcUnit.sv
source/legv8Core.sv
verification/clockGen.sv
verification/legv8Core_properties.sv
verification/legv8CoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the LEGv8 core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG_FILE=sim.log
SIM_BINARY=legv8Sim

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module legv8CoreTb -f files.f -o "$SIM_BINARY"; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$SIM_BINARY" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"

if [ "$simStatus" -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "Verification passed" "$LOG_FILE"; then
	exit 0
fi

echo "Pass message not found in $LOG_FILE"
exit 1
